// File: bench/cache_bank_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module cache_bank_asserts
(
    input wire logic                clk_in,
    input wire logic                reset_in,
    input wire logic                access_ack,
    input wire logic                miss_valid,
    input wire cache_pkg::addr_t    miss_addr,
    input wire logic                miss_ack,
    input wire logic                return_valid,
    input wire cache_pkg::addr_t    return_addr,
    input wire cache_pkg::block_t   return_data,
    input wire logic                return_ack
);

    miss_held: assert property (@(posedge clk_in) disable iff (reset_in)
        (miss_valid && !miss_ack) |=> (miss_valid && $stable(miss_addr)))
        else $error("miss request changed before miss_ack");

    return_held: assert property (@(posedge clk_in) disable iff (reset_in)
        (return_valid && !return_ack)
            |=> (return_valid && $stable(return_addr) && $stable(return_data)))
        else $error("return changed before return_ack");

    ack_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
        access_ack |=> !access_ack)
        else $error("access_ack longer than one cycle");

    one_channel: assert property (@(posedge clk_in) disable iff (reset_in)
        !(miss_valid && return_valid))
        else $error("miss_valid and return_valid high together");

endmodule

bind cache_bank cache_bank_asserts cache_bank_asserts_inst
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .access_ack     (access_ack),
    .miss_valid     (miss_valid),
    .miss_addr      (miss_addr),
    .miss_ack       (miss_ack),
    .return_valid   (return_valid),
    .return_addr    (return_addr),
    .return_data    (return_data),
    .return_ack     (return_ack)
);

`default_nettype wire

// File: bench/cache_bank_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_bank_checker
(
    input wire logic                clk_in,
    input wire logic                reset_in,
    input wire logic                access_valid,
    input wire cache_pkg::addr_t    access_addr,
    input wire logic                access_ack,
    input wire logic                miss_valid,
    input wire cache_pkg::addr_t    miss_addr,
    input wire logic                miss_ack,
    input wire logic                fetched_ack,
    input wire logic                return_valid,
    input wire cache_pkg::addr_t    return_addr,
    input wire cache_pkg::block_t   return_data,
    input wire logic                return_ack,
    input wire logic                report,
    output int                      error_count,
    output int                      ack_count
);
    import cache_pkg::*;

    way_mask_t  m_valid [`CACHE_NUM_SET];
    way_mask_t  m_hist  [`CACHE_NUM_SET];
    tag_t       m_tag   [`CACHE_NUM_SET][`CACHE_NUM_WAY];

    logic       seen_reset = 1'b0;
    logic       in_flight;
    logic       exp_miss;
    logic       miss_seen;
    logic       fetch_seen;
    logic       ack_due;
    logic       miss_prev;
    logic       miss_hold;
    logic       ret_hold;
    logic       reported;
    addr_t      cur_addr;
    addr_t      hold_miss_addr;
    addr_t      hold_ret_addr;
    block_t     hold_ret_data;
    int         return_count;

    // next level data for a block address
    function automatic block_t mem_block(input addr_t a);
        logic [31:0] x;
        x = {18'h0, a[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS]};
        x = x * 32'h9e3779b1;
        x = x ^ (x >> 15);
        return x;
    endfunction

    function automatic way_mask_t lookup(input set_t s, input tag_t t);
        way_mask_t h;
        h = '0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
            h[w] = m_valid[s][w] && (m_tag[s][w] == t);
        return h;
    endfunction

    // first invalid way, then first way with a clear history bit
    function automatic way_mask_t choose_victim(input way_mask_t v, input way_mask_t h);
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
            if (!v[w])
                return way_mask_t'(1 << w);
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
            if (!h[w])
                return way_mask_t'(1 << w);
        return way_mask_t'(1);
    endfunction

    function automatic way_mask_t history_after(input way_mask_t h, input way_mask_t used);
        way_mask_t m;
        m = h | used;
        return (&m) ? used : m;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic complain(input string what);
        $display("%s", what);
        error_count++;
    endtask

    task automatic update_model(input addr_t a);
        set_t       s;
        tag_t       t;
        way_mask_t  used;
        s = a[`CACHE_TAG_LO-1:`CACHE_INDEX_LO];
        t = a[`CACHE_ADDR_BITS-1:`CACHE_TAG_LO];
        used = lookup(s, t);
        if (used == '0)
        begin
            used = choose_victim(m_valid[s], m_hist[s]);
            for (int w = 0; w < `CACHE_NUM_WAY; w++)
                if (used[w])
                    m_tag[s][w] = t;
            m_valid[s] = m_valid[s] | used;
        end
        m_hist[s] = history_after(m_hist[s], used);
    endtask

    initial
    begin
        error_count  = 0;
        ack_count    = 0;
        return_count = 0;
    end

    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            if (seen_reset)
            begin
                compare_value("access_ack", 32'(access_ack), 32'h0);
                compare_value("miss_valid", 32'(miss_valid), 32'h0);
                compare_value("fetched_ack", 32'(fetched_ack), 32'h0);
                compare_value("return_valid", 32'(return_valid), 32'h0);
            end
            seen_reset = 1'b1;
            for (int s = 0; s < `CACHE_NUM_SET; s++)
            begin
                m_valid[s] = '0;
                m_hist[s]  = '0;
            end
            in_flight  = 1'b0;
            miss_seen  = 1'b0;
            fetch_seen = 1'b0;
            ack_due    = 1'b0;
            miss_prev  = 1'b0;
            miss_hold  = 1'b0;
            ret_hold   = 1'b0;
            reported   = 1'b0;
        end
        else
        begin
            // back-pressure stability
            if (miss_hold)
            begin
                compare_value("miss_valid", 32'(miss_valid), 32'h1);
                compare_value("miss_addr", 32'(miss_addr), 32'(hold_miss_addr));
            end
            if (ret_hold)
            begin
                compare_value("return_valid", 32'(return_valid), 32'h1);
                compare_value("return_addr", 32'(return_addr), 32'(hold_ret_addr));
                compare_value("return_data", return_data, hold_ret_data);
            end
            miss_hold      = miss_valid && !miss_ack;
            hold_miss_addr = miss_addr;
            ret_hold       = return_valid && !return_ack;
            hold_ret_addr  = return_addr;
            hold_ret_data  = return_data;

            if (ack_due)
            begin
                if (!access_ack)
                    complain("access_ack missing after return handshake");
                in_flight = 1'b0;
                ack_due   = 1'b0;
            end
            else if (access_ack)
            begin
                complain("access_ack without a return handshake");
            end
            if (access_ack)
                ack_count++;

            if (!in_flight && access_valid && !access_ack)
            begin
                in_flight  = 1'b1;
                cur_addr   = access_addr;
                miss_seen  = 1'b0;
                fetch_seen = 1'b0;
                exp_miss   = lookup(access_addr[`CACHE_TAG_LO-1:`CACHE_INDEX_LO],
                                    access_addr[`CACHE_ADDR_BITS-1:`CACHE_TAG_LO]) == '0;
            end

            if (miss_valid && !miss_prev)
            begin
                if (!in_flight || !exp_miss)
                    complain("miss request for an access the model calls a hit");
                compare_value("miss_addr", 32'(miss_addr),
                              32'({cur_addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS],
                                   `CACHE_OFFSET_BITS'(0)}));
                miss_seen = 1'b1;
            end
            miss_prev = miss_valid;

            // one fetched_ack per miss, after its request
            if (fetched_ack)
            begin
                if (!miss_seen || fetch_seen)
                    complain("fetched_ack without a pending miss");
                fetch_seen = 1'b1;
            end

            if (return_valid && return_ack)
            begin
                if (!in_flight)
                    complain("return with no access in flight");
                if (exp_miss && !miss_seen)
                    complain("return for a miss without a miss request");
                if (exp_miss && !fetch_seen)
                    complain("return for a miss before fetched_ack");
                compare_value("return_addr", 32'(return_addr), 32'(cur_addr));
                compare_value("return_data", return_data, mem_block(cur_addr));
                update_model(cur_addr);
                return_count++;
                ack_due = 1'b1;
            end

            if (report && !reported)
            begin
                reported = 1'b1;
                if (ack_count != return_count)
                    complain("access_ack count differs from return count");
                $display("checker: %0d returns, %0d access acks, %0d errors",
                         return_count, ack_count, error_count);
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/cache_bank_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_bank_tb;
    import cache_pkg::*;

    localparam int NUM_ACCESS = 400;
    localparam int WAIT_LIMIT = 500;

    logic       clk_in;
    logic       reset_in;
    logic       access_valid;
    addr_t      access_addr;
    logic       access_ack;
    logic       miss_valid;
    addr_t      miss_addr;
    logic       miss_ack;
    logic       fetched_valid;
    block_t     fetched_data;
    logic       fetched_ack;
    logic       return_valid;
    addr_t      return_addr;
    block_t     return_data;
    logic       return_ack;
    logic       report;
    int         error_count;
    int         ack_count;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic block_t mem_block(input addr_t a);
        logic [31:0] x;
        x = {18'h0, a[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS]};
        x = x * 32'h9e3779b1;
        x = x ^ (x >> 15);
        return x;
    endfunction

    // eight tags spread over the tag field
    function automatic tag_t tag_of(input logic [2:0] n);
        return tag_t'(12'h0a5 + 12'h111 * {9'h0, n});
    endfunction

    cache_bank cache_bank_inst
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .access_valid   (access_valid),
        .access_addr    (access_addr),
        .access_ack     (access_ack),
        .miss_valid     (miss_valid),
        .miss_addr      (miss_addr),
        .miss_ack       (miss_ack),
        .fetched_valid  (fetched_valid),
        .fetched_data   (fetched_data),
        .fetched_ack    (fetched_ack),
        .return_valid   (return_valid),
        .return_addr    (return_addr),
        .return_data    (return_data),
        .return_ack     (return_ack)
    );

    cache_bank_checker cache_bank_checker
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .access_valid   (access_valid),
        .access_addr    (access_addr),
        .access_ack     (access_ack),
        .miss_valid     (miss_valid),
        .miss_addr      (miss_addr),
        .miss_ack       (miss_ack),
        .fetched_ack    (fetched_ack),
        .return_valid   (return_valid),
        .return_addr    (return_addr),
        .return_data    (return_data),
        .return_ack     (return_ack),
        .report         (report),
        .error_count    (error_count),
        .ack_count      (ack_count)
    );

    initial
    begin
        clk_in = 1'b0;
        forever
            #10 clk_in = ~clk_in;
    end

    // requester
    initial
    begin
        logic [31:0]    rs;
        int             waited;
        rs           = 32'd49;
        reset_in     = 1'b1;
        report       = 1'b0;
        access_valid = 1'b0;
        access_addr  = '0;
        repeat (8) @(negedge clk_in);
        reset_in = 1'b0;
        @(negedge clk_in);
        for (int i = 0; i < NUM_ACCESS; i++)
        begin
            rs           = xorshift(rs);
            access_addr  = {tag_of(rs[2:0]), rs[13:12], rs[9:8]};
            access_valid = 1'b1;
            waited       = 0;
            @(negedge clk_in);
            while (!access_ack && waited < WAIT_LIMIT)
            begin
                @(negedge clk_in);
                waited++;
            end
            if (!access_ack)
            begin
                $display("timeout waiting for access_ack on access %0d", i);
                $display("Test FAILED");
                $finish;
            end
            access_valid = 1'b0;
            repeat (int'(rs[17:16])) @(negedge clk_in);
        end
        report = 1'b1;
        @(negedge clk_in);
        if (error_count == 0 && ack_count == NUM_ACCESS)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // return_ack with 0 to 4 stall cycles
    initial
    begin
        logic [31:0]    rs;
        int             stall;
        rs         = xorshift(32'd49 ^ 32'h0000_0f00);
        stall      = int'(rs[7:0]) % 5;
        return_ack = 1'b0;
        forever
        begin
            @(negedge clk_in);
            rs = xorshift(rs);
            if (return_ack)
            begin
                return_ack = 1'b0;
                stall      = int'(rs[7:0]) % 5;
            end
            else if (return_valid)
            begin
                if (stall == 0)
                    return_ack = 1'b1;
                else
                    stall--;
            end
        end
    end

    // next level memory
    initial
    begin
        logic [31:0]    rs;
        int             ack_wait;
        int             fetch_wait;
        logic           fetching;
        addr_t          fetch_addr;
        rs            = xorshift(32'd49 ^ 32'h00f0_0000);
        ack_wait      = -1;
        fetch_wait    = 0;
        fetching      = 1'b0;
        fetch_addr    = '0;
        miss_ack      = 1'b0;
        fetched_valid = 1'b0;
        fetched_data  = '0;
        forever
        begin
            @(negedge clk_in);
            rs = xorshift(rs);
            if (miss_ack)
            begin
                miss_ack   = 1'b0;
                fetching   = 1'b1;
                fetch_wait = int'(rs[7:0]) % 6;
            end
            else if (fetched_valid)
            begin
                if (fetched_ack)
                    fetched_valid = 1'b0;
            end
            else if (fetching)
            begin
                if (fetch_wait == 0)
                begin
                    fetched_valid = 1'b1;
                    fetched_data  = mem_block(fetch_addr);
                    fetching      = 1'b0;
                end
                else
                    fetch_wait--;
            end
            else if (miss_valid)
            begin
                if (ack_wait < 0)
                    ack_wait = int'(rs[15:8]) % 4;
                if (ack_wait == 0)
                begin
                    miss_ack   = 1'b1;
                    fetch_addr = miss_addr;
                end
                ack_wait--;
            end
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_ifs.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/way_select.sv
verilog/bank_ctrl.sv
verilog/cache_bank.sv
bench/cache_bank_asserts.sv
bench/cache_bank_checker.sv
bench/cache_bank_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module cache_bank_tb -o sim_cache_bank
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_cache_bank)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: verilog/bank_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module bank_ctrl
(
    input wire logic                clk_in,
    input wire logic                reset_in,

    input wire logic                access_valid,
    input wire cache_pkg::addr_t    access_addr,
    output logic                    access_ack,

    output logic                    miss_valid,
    output cache_pkg::addr_t        miss_addr,
    input wire logic                miss_ack,

    input wire logic                fetched_valid,
    input wire cache_pkg::block_t   fetched_data,
    output logic                    fetched_ack,

    output logic                    return_valid,
    output cache_pkg::addr_t        return_addr,
    output cache_pkg::block_t       return_data,
    input wire logic                return_ack,

    tag_array_if.master             tag_port,
    data_array_if.master            data_port,

    input wire cache_pkg::way_mask_t hit,
    input wire cache_pkg::way_mask_t victim,
    input wire cache_pkg::way_mask_t next_history
);
    import cache_pkg::*;

    bank_state_t    state;
    addr_t          acc_addr;
    way_mask_t      fill_way;
    way_mask_t      fill_history;
    set_t           acc_set;
    tag_t           acc_tag;
    logic           accept;
    logic           hit_check;
    logic           fill;

    // access_ack still high means the last access is being released
    assign accept    = (state == IDLE) && access_valid && !access_ack;
    assign hit_check = (state == CHECK) && (|hit);
    assign fill      = (state == MISS_WAIT) && fetched_valid;

    assign acc_set = acc_addr[`CACHE_TAG_LO-1:`CACHE_INDEX_LO];
    assign acc_tag = acc_addr[`CACHE_ADDR_BITS-1:`CACHE_TAG_LO];

    assign miss_addr   = {acc_addr[`CACHE_ADDR_BITS-1:`CACHE_INDEX_LO],
                          {`CACHE_OFFSET_BITS{1'b0}}};
    assign return_addr = acc_addr;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state        <= IDLE;
            access_ack   <= 1'b0;
            miss_valid   <= 1'b0;
            fetched_ack  <= 1'b0;
            return_valid <= 1'b0;
        end
        else
        begin
            access_ack  <= 1'b0;
            fetched_ack <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (accept)
                        state <= CHECK;
                end
                CHECK:
                begin
                    if (|hit)
                    begin
                        state <= READ_HIT;
                    end
                    else
                    begin
                        state      <= MISS_REQ;
                        miss_valid <= 1'b1;
                    end
                end
                READ_HIT:
                begin
                    state        <= RETURN;
                    return_valid <= 1'b1;
                end
                MISS_REQ:
                begin
                    if (miss_ack)
                    begin
                        state      <= MISS_WAIT;
                        miss_valid <= 1'b0;
                    end
                end
                MISS_WAIT:
                begin
                    if (fetched_valid)
                    begin
                        state        <= RETURN;
                        fetched_ack  <= 1'b1;
                        return_valid <= 1'b1;
                    end
                end
                RETURN:
                begin
                    if (return_ack)
                    begin
                        state        <= IDLE;
                        return_valid <= 1'b0;
                        access_ack   <= 1'b1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
            acc_addr <= access_addr;
        // victim and its history kept for the fill
        if (state == CHECK)
        begin
            fill_way     <= victim;
            fill_history <= next_history;
        end
        if (state == READ_HIT)
            return_data <= data_port.read_data;
        else if (fill)
            return_data <= fetched_data;
    end

    // array commands take effect on the edge that ends the current state
    always_comb
    begin
        tag_port.access_en        = accept || fill;
        tag_port.write_en         = fill;
        tag_port.history_write_en = hit_check;
        tag_port.set              = accept ? access_addr[`CACHE_TAG_LO-1:`CACHE_INDEX_LO]
                                           : acc_set;
        tag_port.way_select       = fill_way;
        tag_port.write_tag        = acc_tag;
        tag_port.write_valid      = fill_way;
        tag_port.write_history    = (state == CHECK) ? next_history : fill_history;

        data_port.access_en       = hit_check || fill;
        data_port.write_en        = fill;
        data_port.way_select      = fill ? fill_way : hit;
        data_port.set             = acc_set;
        data_port.write_data      = fetched_data;
    end

endmodule

`default_nettype wire

// File: verilog/cache_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_bank
(
    input wire logic                clk_in,
    input wire logic                reset_in,

    input wire logic                access_valid,
    input wire cache_pkg::addr_t    access_addr,
    output logic                    access_ack,

    output logic                    miss_valid,
    output cache_pkg::addr_t        miss_addr,
    input wire logic                miss_ack,

    input wire logic                fetched_valid,
    input wire cache_pkg::block_t   fetched_data,
    output logic                    fetched_ack,

    output logic                    return_valid,
    output cache_pkg::addr_t        return_addr,
    output cache_pkg::block_t       return_data,
    input wire logic                return_ack
);
    import cache_pkg::*;

    way_mask_t  hit;
    way_mask_t  victim;
    way_mask_t  next_history;

    tag_array_if  tag_bus ();
    data_array_if data_bus ();

    bank_ctrl bank_ctrl_inst
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .access_valid   (access_valid),
        .access_addr    (access_addr),
        .access_ack     (access_ack),
        .miss_valid     (miss_valid),
        .miss_addr      (miss_addr),
        .miss_ack       (miss_ack),
        .fetched_valid  (fetched_valid),
        .fetched_data   (fetched_data),
        .fetched_ack    (fetched_ack),
        .return_valid   (return_valid),
        .return_addr    (return_addr),
        .return_data    (return_data),
        .return_ack     (return_ack),
        .tag_port       (tag_bus),
        .data_port      (data_bus),
        .hit            (hit),
        .victim         (victim),
        .next_history   (next_history)
    );

    // return_addr holds the accepted address for the whole access
    way_select way_select_inst
    (
        .access_tag     (return_addr[`CACHE_ADDR_BITS-1:`CACHE_TAG_LO]),
        .tag_port       (tag_bus),
        .hit            (hit),
        .victim         (victim),
        .next_history   (next_history)
    );

    tag_array tag_array_inst
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .tag_port       (tag_bus)
    );

    data_array data_array_inst
    (
        .clk_in         (clk_in),
        .data_port      (data_bus)
    );

endmodule

`default_nettype wire

// File: verilog/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// geometry of one bank
`define CACHE_ADDR_BITS     16
`define CACHE_NUM_SET       4
`define CACHE_NUM_WAY       4
`define CACHE_BLOCK_BYTES   4
`define CACHE_BYTE_BITS     8

// address split: tag | index | offset
`define CACHE_OFFSET_BITS   2
`define CACHE_INDEX_BITS    2
`define CACHE_INDEX_LO      `CACHE_OFFSET_BITS
`define CACHE_TAG_LO        (`CACHE_INDEX_LO + `CACHE_INDEX_BITS)
`define CACHE_TAG_BITS      (`CACHE_ADDR_BITS - `CACHE_TAG_LO)

`endif

// File: verilog/cache_ifs.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

interface tag_array_if;
    import cache_pkg::*;

    logic                           access_en;
    logic                           write_en;
    logic                           history_write_en;
    set_t                           set;
    way_mask_t                      way_select;
    tag_t                           write_tag;
    way_mask_t                      write_valid;
    way_mask_t                      write_history;
    way_mask_t                      read_valid;
    tag_t [`CACHE_NUM_WAY-1:0]      read_tags;
    way_mask_t                      read_history;

    modport master (
        output access_en, write_en, history_write_en, set, way_select,
        output write_tag, write_valid, write_history,
        input  read_valid, read_tags, read_history
    );

    modport slave (
        input  access_en, write_en, history_write_en, set, way_select,
        input  write_tag, write_valid, write_history,
        output read_valid, read_tags, read_history
    );

    // read results only, for the hit and victim logic
    modport monitor (
        input read_valid, read_tags, read_history
    );
endinterface

interface data_array_if;
    import cache_pkg::*;

    logic       access_en;
    logic       write_en;
    way_mask_t  way_select;
    set_t       set;
    block_t     write_data;
    block_t     read_data;

    modport master (
        output access_en, write_en, way_select, set, write_data,
        input  read_data
    );

    modport slave (
        input  access_en, write_en, way_select, set, write_data,
        output read_data
    );
endinterface

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0]  addr_t;
    typedef logic [`CACHE_TAG_BITS-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] set_t;
    typedef logic [`CACHE_BLOCK_BYTES*`CACHE_BYTE_BITS-1:0] block_t;

    // one bit per way
    typedef logic [`CACHE_NUM_WAY-1:0] way_mask_t;

    typedef enum logic [2:0]
    {
        IDLE,
        CHECK,
        READ_HIT,
        MISS_REQ,
        MISS_WAIT,
        RETURN
    } bank_state_t;

endpackage

`default_nettype wire

// File: verilog/data_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module data_array
(
    input wire logic    clk_in,
    data_array_if.slave data_port
);
    import cache_pkg::*;

    block_t mem_q [`CACHE_NUM_SET][`CACHE_NUM_WAY];
    block_t sel_data;

    // one-hot way select, so an OR picks the block
    always_comb
    begin
        sel_data = '0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            if (data_port.way_select[w])
                sel_data = sel_data | mem_q[data_port.set][w];
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (data_port.access_en && data_port.write_en)
        begin
            for (int w = 0; w < `CACHE_NUM_WAY; w++)
            begin
                if (data_port.way_select[w])
                    mem_q[data_port.set][w] <= data_port.write_data;
            end
        end
        if (data_port.access_en && !data_port.write_en)
        begin
            data_port.read_data <= sel_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/tag_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module tag_array
(
    input wire logic    clk_in,
    input wire logic    reset_in,
    tag_array_if.slave  tag_port
);
    import cache_pkg::*;

    way_mask_t  valid_q   [`CACHE_NUM_SET];
    way_mask_t  history_q [`CACHE_NUM_SET];
    tag_t       tags_q    [`CACHE_NUM_SET][`CACHE_NUM_WAY];
    logic       do_write;
    logic       do_read;

    assign do_write = tag_port.access_en && tag_port.write_en;
    assign do_read  = tag_port.access_en && !tag_port.write_en;

    // valid and history words, cleared in reset
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            for (int s = 0; s < `CACHE_NUM_SET; s++)
            begin
                valid_q[s]   <= '0;
                history_q[s] <= '0;
            end
        end
        else
        begin
            if (do_write)
            begin
                valid_q[tag_port.set] <= (valid_q[tag_port.set] & ~tag_port.way_select)
                                       | (tag_port.write_valid & tag_port.way_select);
            end
            // history also written alone on a hit
            if (do_write || tag_port.history_write_en)
            begin
                history_q[tag_port.set] <= tag_port.write_history;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (do_write)
        begin
            for (int w = 0; w < `CACHE_NUM_WAY; w++)
            begin
                if (tag_port.way_select[w])
                    tags_q[tag_port.set][w] <= tag_port.write_tag;
            end
        end
        if (do_read)
        begin
            tag_port.read_valid   <= valid_q[tag_port.set];
            tag_port.read_history <= history_q[tag_port.set];
            for (int w = 0; w < `CACHE_NUM_WAY; w++)
            begin
                tag_port.read_tags[w] <= tags_q[tag_port.set][w];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/way_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module way_select
(
    input wire cache_pkg::tag_t     access_tag,
    tag_array_if.monitor            tag_port,
    output cache_pkg::way_mask_t    hit,
    output cache_pkg::way_mask_t    victim,
    output cache_pkg::way_mask_t    next_history
);
    import cache_pkg::*;

    way_mask_t  used;
    way_mask_t  merged;
    logic       found;

    always_comb
    begin
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            hit[w] = tag_port.read_valid[w] && (tag_port.read_tags[w] == access_tag);
        end
    end

    // first invalid way, else first way with history clear
    always_comb
    begin
        victim = '0;
        found  = 1'b0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            if (!found && !tag_port.read_valid[w])
            begin
                victim[w] = 1'b1;
                found     = 1'b1;
            end
        end
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            if (!found && !tag_port.read_history[w])
            begin
                victim[w] = 1'b1;
                found     = 1'b1;
            end
        end
        if (!found)
            victim[0] = 1'b1;
    end

    assign used   = (|hit) ? hit : victim;
    assign merged = tag_port.read_history | used;

    // a full history word restarts from the used way
    assign next_history = (&merged) ? used : merged;

endmodule

`default_nettype wire
